// ==== design/motorPwmPkg.sv ====
package motorPwmPkg;

    // width of every position word (sums, remainders, lost counts)
    localparam int POS_WIDTH = 16;

    // width of the pwm period and minimum pulse fields
    localparam int PWM_WIDTH = 12;

    // commutation sequence length and the step number width it implies
    localparam int STEP_COUNT = 16;
    localparam int STEP_WIDTH = $clog2(STEP_COUNT);

    // widest step counter the timing bundle can carry
    // narrower timers are zero extended into it
    localparam int STEP_CNT_MAX = 25;

    // steps where a phase checks its sum against a neighbour
    localparam logic [STEP_WIDTH-1:0] STEP_COMPARE_B = STEP_WIDTH'(6);
    localparam logic [STEP_WIDTH-1:0] STEP_COMPARE_C = STEP_WIDTH'(11);

    // steps where the running loss restarts from the last step's loss
    localparam logic [STEP_WIDTH-1:0] STEP_RESYNC_0 = STEP_WIDTH'(1);
    localparam logic [STEP_WIDTH-1:0] STEP_RESYNC_1 = STEP_WIDTH'(7);

    // pwm settings shared by all three phases
    typedef struct packed {
        logic [PWM_WIDTH-1:0] pwmLenWant;
        logic [PWM_WIDTH-1:0] pwmMin;
    } pwmConfig_t;

    // step timer outputs, strobes are one cycle apart
    typedef struct packed {
        logic [STEP_CNT_MAX-1:0] stepCnt;
        logic                    first1;
        logic                    first2;
        logic                    last1;
        logic                    last2;
    } stepTiming_t;

    // per phase results
    typedef struct packed {
        logic                 pwm;
        logic [POS_WIDTH-1:0] posSum;
        logic [POS_WIDTH-1:0] posLost;
    } phaseStatus_t;

endpackage

// ==== design/stepTimer.sv ====
module stepTimer #(
    parameter int STEP_CNT_WIDTH = 10
) (
    input  logic                     clk,
    input  logic                     rst,
    output motorPwmPkg::stepTiming_t timing
);
    import motorPwmPkg::*;

    // last count of a step
    localparam logic [STEP_CNT_WIDTH-1:0] CNT_TOP = '1;

    logic [STEP_CNT_WIDTH-1:0] cnt;
    logic [STEP_CNT_WIDTH-1:0] cntNext;
    logic                      first1;
    logic                      first2;
    logic                      last1;
    logic                      last2;

    assign cntNext = cnt + 1'b1;

    // counter parks on the top value in reset
    // so the first cycle out of reset is count 0 of step 0
    // strobes are decoded from the next count and land with it
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= CNT_TOP;
            first1 <= 1'b0;
            first2 <= 1'b0;
            last1  <= 1'b0;
            last2  <= 1'b0;
        end else begin
            cnt    <= cntNext;
            // step opens
            first1 <= (cntNext == '0);
            first2 <= (cntNext == STEP_CNT_WIDTH'(1));
            // step closes, last1 one cycle ahead of last2
            last1  <= (cntNext == CNT_TOP - 1'b1);
            last2  <= (cntNext == CNT_TOP);
        end
    end

    // pack the bundle for control and phases
    always_comb begin
        timing.stepCnt = STEP_CNT_MAX'(cnt);
        timing.first1  = first1;
        timing.first2  = first2;
        timing.last1   = last1;
        timing.last2   = last2;
    end

endmodule

// ==== design/commutationControl.sv ====
module commutationControl (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       enable,
    input  motorPwmPkg::stepTiming_t                   timing,
    output logic [motorPwmPkg::STEP_WIDTH-1:0]         sgStep,
    output logic [2:0][motorPwmPkg::STEP_WIDTH-1:0]    phaseStep,
    output logic                                       pwmActive
);
    import motorPwmPkg::*;

    // last state of the commutation walk
    localparam logic [STEP_WIDTH-1:0] STEP_LAST = STEP_WIDTH'(STEP_COUNT - 1);

    // per phase offset into the sequence
    // phase A leads, B trails by 5 steps, C by 10
    localparam logic [2:0][STEP_WIDTH-1:0] PHASE_OFFSET = {
        STEP_WIDTH'(10),
        STEP_WIDTH'(5),
        STEP_WIDTH'(0)
    };

    logic [STEP_WIDTH-1:0] stepNext;

    // wrap explicitly at the sequence length
    assign stepNext = (sgStep == STEP_LAST) ? '0 : sgStep + 1'b1;

    // commutation position
    // moves on the edge that closes last2, so the new step
    // is already valid in the first1 cycle of the next step
    always_ff @(posedge clk) begin
        if (rst) begin
            sgStep <= '0;
        end else if (timing.last2) begin
            sgStep <= stepNext;
        end
    end

    // enable is a raw level, register once before the phases see it
    always_ff @(posedge clk) begin
        if (rst) begin
            pwmActive <= 1'b0;
        end else begin
            pwmActive <= enable;
        end
    end

    // spread the sequence over the three phases
    // the sum is STEP_WIDTH bits wide, so it wraps mod STEP_COUNT
    always_comb begin
        for (int p = 0; p < 3; p++) begin
            phaseStep[p] = sgStep + PHASE_OFFSET[p];
        end
    end

endmodule

// ==== design/phasePulseGenerator.sv ====
module phasePulseGenerator (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   pwmActive,
    input  motorPwmPkg::stepTiming_t               timing,
    input  logic [motorPwmPkg::STEP_WIDTH-1:0]     step,
    input  logic [motorPwmPkg::POS_WIDTH-1:0]      plLen,
    input  motorPwmPkg::pwmConfig_t                cfg,
    input  logic [motorPwmPkg::POS_WIDTH-1:0]      extB,
    input  logic [motorPwmPkg::POS_WIDTH-1:0]      extC,
    output motorPwmPkg::phaseStatus_t              status
);
    import motorPwmPkg::*;

    logic [PWM_WIDTH-1:0] pwmCnt;
    logic                 reloadNow;
    logic                 loadPoint;
    logic [POS_WIDTH-1:0] pulseCnt;
    logic                 pwm;
    logic [POS_WIDTH-1:0] posRemain;
    logic [POS_WIDTH-1:0] posSum;
    logic [POS_WIDTH-1:0] pwmMinNow;
    logic                 minOk;
    logic                 posLoad;
    logic [POS_WIDTH-1:0] carrySum;
    logic [POS_WIDTH-1:0] wantAcc;
    logic [POS_WIDTH-1:0] wantTotal;
    logic [POS_WIDTH-1:0] realAcc;
    logic [POS_WIDTH-1:0] realTotal;
    logic [POS_WIDTH-1:0] lostStep;
    logic [POS_WIDTH-1:0] posLost;

    // period counter reloads at the end of a period, at last1,
    // and is held at the reload value while the stage is idle
    assign reloadNow = !pwmActive || timing.last1 || (pwmCnt == PWM_WIDTH'(1));
    // only reloads of a running stage may start a pulse
    assign loadPoint = reloadNow && pwmActive;

    always_ff @(posedge clk) begin
        if (rst) begin
            pwmCnt <= cfg.pwmLenWant;
        end else if (reloadNow) begin
            pwmCnt <= cfg.pwmLenWant;
        end else begin
            pwmCnt <= pwmCnt - 1'b1;
        end
    end

    // position wanted now: carried remainder plus this step's length
    assign posSum    = posRemain + plLen;
    assign pwmMinNow = POS_WIDTH'(cfg.pwmMin);
    assign minOk     = (posSum >= pwmMinNow);

    // at the compare steps the pulse may not exceed the neighbour's sum
    always_comb begin
        case (step)
            STEP_COMPARE_C: posLoad = minOk && (posSum <= extC);
            STEP_COMPARE_B: posLoad = minOk && (posSum <= extB);
            default:        posLoad = minOk;
        endcase
    end

    // pulse timer, pwm is high while it is nonzero
    // a load at cycle n gives posSum high cycles starting at n+1
    always_ff @(posedge clk) begin
        if (rst) begin
            pulseCnt <= '0;
        end else if (!pwmActive) begin
            pulseCnt <= '0;
        end else if (loadPoint && posLoad) begin
            pulseCnt <= posSum;
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - 1'b1;
        end
    end

    assign pwm = (pulseCnt != '0);

    // what the last load point left behind
    // a sum that did not fit is kept and becomes the remainder on first1
    always_ff @(posedge clk) begin
        if (rst) begin
            carrySum  <= '0;
            posRemain <= '0;
        end else if (!pwmActive) begin
            // nothing carries across an idle stretch
            carrySum  <= '0;
            posRemain <= '0;
        end else begin
            if (loadPoint) begin
                carrySum <= posLoad ? '0 : posSum;
            end
            if (timing.first1) begin
                posRemain <= carrySum;
            end
        end
    end

    // wanted position per step, latched at the close of the step
    always_ff @(posedge clk) begin
        if (rst) begin
            wantAcc   <= '0;
            wantTotal <= '0;
        end else if (timing.last2) begin
            wantTotal <= wantAcc;
            wantAcc   <= '0;
        end else if (timing.first1 && pwmActive) begin
            wantAcc <= wantAcc + plLen;
        end
    end

    // produced high time over first1..last2 of the step
    // the last2 cycle itself is folded in as the total is latched
    always_ff @(posedge clk) begin
        if (rst) begin
            realAcc   <= '0;
            realTotal <= '0;
        end else if (timing.last2) begin
            realTotal <= realAcc + POS_WIDTH'(pwm);
            realAcc   <= '0;
        end else if (pwm) begin
            realAcc <= realAcc + 1'b1;
        end
    end

    // shortfall of the step just closed
    assign lostStep = wantTotal - realTotal;

    // running loss, restarted at the two resync steps
    always_ff @(posedge clk) begin
        if (rst) begin
            posLost <= '0;
        end else if (timing.first1) begin
            if (step == STEP_RESYNC_0 || step == STEP_RESYNC_1) begin
                posLost <= lostStep;
            end else begin
                posLost <= posLost + lostStep;
            end
        end
    end

    always_comb begin
        status.pwm     = pwm;
        status.posSum  = posSum;
        status.posLost = posLost;
    end

endmodule

// ==== design/motorPwmTop.sv ====
module motorPwmTop #(
    parameter int STEP_CNT_WIDTH = 10
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 enable,
    input  logic [motorPwmPkg::POS_WIDTH-1:0]    plLen,
    input  motorPwmPkg::pwmConfig_t              cfg,
    output motorPwmPkg::phaseStatus_t [2:0]      phase,
    output logic [motorPwmPkg::STEP_WIDTH-1:0]   sgStep,
    output logic                                 stepStart
);
    import motorPwmPkg::*;

    stepTiming_t                timing;
    logic [2:0][STEP_WIDTH-1:0] phaseStep;
    logic                       pwmActive;

    // step boundaries for everything below
    stepTimer #(
        .STEP_CNT_WIDTH (STEP_CNT_WIDTH)
    ) uStepTimer (
        .clk    (clk),
        .rst    (rst),
        .timing (timing)
    );

    // commutation walk and registered enable
    commutationControl uCommutation (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .timing    (timing),
        .sgStep    (sgStep),
        .phaseStep (phaseStep),
        .pwmActive (pwmActive)
    );

    // step start marker for the outside world
    assign stepStart = timing.first1;

    // three identical phases
    // each sees the next phase as B and the one after as C
    for (genvar p = 0; p < 3; p++) begin : gPhase
        phasePulseGenerator uPhase (
            .clk       (clk),
            .rst       (rst),
            .pwmActive (pwmActive),
            .timing    (timing),
            .step      (phaseStep[p]),
            .plLen     (plLen),
            .cfg       (cfg),
            .extB      (phase[(p + 1) % 3].posSum),
            .extC      (phase[(p + 2) % 3].posSum),
            .status    (phase[p])
        );
    end

endmodule

// ==== verif/motorPwmTb.sv ====
module motorPwmTb;
    timeunit 1ns;
    timeprecision 100ps;

    import motorPwmPkg::*;

    // row layout is enable plLen pwmLenWant pwmMin steps, high x3, lost x3
    localparam int COLS = 11;
    localparam int NUM_ROWS = 6;
    localparam int MAX_WIN = 128;
    localparam int CNT_WIDTH = 8;
    localparam int STEP_CLOCKS = 1 << CNT_WIDTH;

    logic clk;
    logic rst;
    logic enable;
    logic [POS_WIDTH-1:0] plLen;
    pwmConfig_t cfg;
    phaseStatus_t [2:0] phase;
    logic [STEP_WIDTH-1:0] sgStep;
    logic stepStart;

    logic [15:0] patterns [0:NUM_ROWS*COLS-1];
    logic patternsLoaded;
    int seed;

    // per window records indexed by the step start that closed the window
    int closedHigh [0:MAX_WIN-1][0:2];
    logic [15:0] lostRec [0:MAX_WIN-1][0:2];
    int stepsSeen;
    int lostCount;

    motorPwmTop #(
        .STEP_CNT_WIDTH (CNT_WIDTH)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .plLen     (plLen),
        .cfg       (cfg),
        .phase     (phase),
        .sgStep    (sgStep),
        .stepStart (stepStart)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] got);
        if (got !== expected) begin
            $display("FAILED %s expected %h got %h", name, expected, got);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // observer sampling on the falling edge where everything is settled
    initial begin : monitor
        logic enableSeen;
        logic activeNow;
        logic activeLast;
        logic [STEP_WIDTH-1:0] expStep;
        logic [STEP_WIDTH-1:0] phStep;
        logic [15:0] wantWin;
        logic [15:0] lostStep;
        logic [15:0] newLost;
        logic [15:0] expSum;
        logic [15:0] expLost [0:2];
        logic [15:0] oldLost [0:2];
        logic [15:0] remain [0:2];
        logic [15:0] loadSum [0:2];
        logic resetStep [0:2];
        logic loadOk;
        int highCnt [0:2];
        int cycleCnt;
        logic lostPending;
        stepsSeen = 0;
        lostCount = 0;
        enableSeen = 1'b0;
        activeLast = 1'b0;
        expStep = '0;
        wantWin = '0;
        cycleCnt = 0;
        lostPending = 1'b0;
        for (int p = 0; p < 3; p++) begin
            expLost[p] = '0;
            oldLost[p] = '0;
            remain[p] = '0;
            resetStep[p] = 1'b0;
            highCnt[p] = 0;
        end
        @(negedge rst);
        forever begin
            @(negedge clk);
            cycleCnt++;
            // enable registered once inside the DUT
            activeNow = enableSeen;
            // loss lands one cycle after the step start
            if (lostPending) begin
                for (int p = 0; p < 3; p++) begin
                    newLost = phase[p].posLost;
                    checkValue($sformatf("phase%0d.posLost", p), 32'(expLost[p]),
                               32'(newLost));
                    lostRec[stepsSeen][p] = resetStep[p] ? newLost : newLost - oldLost[p];
                    // remainder taken on first1 plus the current length
                    expSum = remain[p] + plLen;
                    checkValue($sformatf("phase%0d.posSum", p), 32'(expSum),
                               32'(phase[p].posSum));
                end
                lostPending = 1'b0;
                lostCount = stepsSeen;
            end
            if (stepStart) begin
                // steps are 2**CNT_WIDTH clocks apart
                if (stepsSeen > 0) begin
                    checkValue("stepStart period", STEP_CLOCKS, cycleCnt);
                end
                cycleCnt = 0;
                stepsSeen++;
                checkValue("sgStep", 32'(expStep), 32'(sgStep));
                // replay the load decision taken at last1 of the window just closed
                for (int p = 0; p < 3; p++) begin
                    loadSum[p] = remain[p] + plLen;
                end
                for (int p = 0; p < 3; p++) begin
                    phStep = expStep - 1'b1 + STEP_WIDTH'(5 * p);
                    loadOk = (loadSum[p] >= 16'(cfg.pwmMin));
                    // compare steps also cap the sum at a neighbour's sum
                    if (phStep == 4'd6) begin
                        loadOk = loadOk && (loadSum[p] <= loadSum[(p + 1) % 3]);
                    end else if (phStep == 4'd11) begin
                        loadOk = loadOk && (loadSum[p] <= loadSum[(p + 2) % 3]);
                    end
                    // a sum that did not load carries while idle clears it
                    remain[p] = (activeNow && !loadOk) ? loadSum[p] : 16'h0;
                end
                for (int p = 0; p < 3; p++) begin
                    closedHigh[stepsSeen][p] = highCnt[p];
                    lostStep = wantWin - 16'(highCnt[p]);
                    // B trails by 5, C by 10
                    phStep = expStep + STEP_WIDTH'(5 * p);
                    resetStep[p] = (phStep == 4'd1) || (phStep == 4'd7);
                    expLost[p] = resetStep[p] ? lostStep : expLost[p] + lostStep;
                    oldLost[p] = phase[p].posLost;
                    highCnt[p] = 0;
                end
                // wanted length of the window that opens here
                wantWin = activeNow ? plLen : 16'h0;
                expStep = expStep + 1'b1;
                lostPending = 1'b1;
            end
            for (int p = 0; p < 3; p++) begin
                if (!activeLast) begin
                    checkValue($sformatf("phase%0d.pwm", p), 32'h0, 32'(phase[p].pwm));
                end
                highCnt[p] += int'(phase[p].pwm);
            end
            activeLast = activeNow;
            enableSeen = enable;
        end
    end

    // drive one row of settings a few dozen cycles into a step
    task automatic applyRow(input int r);
        int jitter;
        jitter = $unsigned($random(seed)) % 8;
        repeat (60 + jitter) @(posedge clk);
        #1;
        enable         = patterns[r*COLS][0];
        plLen          = patterns[r*COLS+1];
        cfg.pwmLenWant = patterns[r*COLS+2][PWM_WIDTH-1:0];
        cfg.pwmMin     = patterns[r*COLS+3][PWM_WIDTH-1:0];
    endtask

    initial begin : stimulus
        int base;
        int steps;
        int sumHigh;
        logic [15:0] sumLost;
        seed = 32'hebc9_45a3;
        rst = 1'b1;
        enable = 1'b0;
        plLen = '0;
        cfg = '0;
        patternsLoaded = 1'b0;
        $readmemh("verif/motorPwmPatterns.txt", patterns);
        patternsLoaded = 1'b1;
        // outputs quiet through reset
        repeat (4) begin
            @(posedge clk);
            @(negedge clk);
            checkValue("sgStep", 32'h0, 32'(sgStep));
            for (int p = 0; p < 3; p++) begin
                checkValue($sformatf("phase%0d.pwm", p), 32'h0, 32'(phase[p].pwm));
            end
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        wait (lostCount >= 1);
        for (int r = 0; r < NUM_ROWS; r++) begin
            base = lostCount;
            steps = int'(patterns[r*COLS+4]);
            applyRow(r);
            // partial step, then full windows 0..steps-1
            wait (lostCount >= base + 1 + steps);
            // window 0 still carries the previous row
            for (int p = 0; p < 3; p++) begin
                sumHigh = 0;
                sumLost = '0;
                for (int i = 1; i < steps; i++) begin
                    sumHigh += closedHigh[base+2+i][p];
                    sumLost += lostRec[base+2+i][p];
                end
                checkValue($sformatf("row%0d phase%0d high", r, p),
                           32'(patterns[r*COLS+5+p]), sumHigh);
                checkValue($sformatf("row%0d phase%0d lost", r, p),
                           32'(patterns[r*COLS+8+p]), 32'(sumLost));
            end
        end
        $display("All tests passed!");
        $finish;
    end

    // bound from the pattern lengths with one step of STEP_CLOCKS clocks at 4 ns
    initial begin : watchdog
        longint limitNs;
        int totalSteps;
        wait (patternsLoaded);
        totalSteps = 2;
        for (int r = 0; r < NUM_ROWS; r++) begin
            totalSteps += int'(patterns[r*COLS+4]) + 1;
        end
        limitNs = longint'(totalSteps) * STEP_CLOCKS * 4 + 2000;
        #(limitNs);
        $display("timeout: the pattern run did not finish in time");
        $display("Test failures found");
        $fatal(1);
    end

endmodule

// ==== verif/motorPwmPatterns.txt ====
// enable plLen pwmLenWant pwmMin steps | high total A B C | lost total A B C
// totals cover windows 1..steps-1 of each row
0 0030 0fff 0020 0003 0000 0000 0000 0000 0000 0000
// steady pulses of plLen
1 0040 0fff 0020 0006 0140 0140 0140 0000 0000 0000
// below minimum, remainder carries to a 120 cycle pulse
1 0028 0fff 0064 0006 00f0 00f0 00f0 ffd8 ffd8 ffd8
// idle again clears the remainder
0 0028 0fff 0064 0003 0000 0000 0000 0000 0000 0000
1 00c8 0fff 0010 0005 0320 0320 0320 0000 0000 0000
1 0018 0fff 0040 0008 0091 0091 0091 0017 0017 0017

// ==== project.f ====
design/motorPwmPkg.sv
design/stepTimer.sv
design/commutationControl.sv
design/phasePulseGenerator.sv
design/motorPwmTop.sv
verif/motorPwmTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --top-module motorPwmTb -f project.f -o motorPwmSim

# the simulator status is ignored here, the log decides
./obj_dir/motorPwmSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation PASSED"
